// ==== logic/stream_pkg.sv ====
`default_nettype none

package stream_pkg;

    ////////////////////
    // Sequence tag

    // Width of the tag carried with each sample
    localparam int SEQ_WIDTH = 4;

    // Counts accepted samples, wraps modulo 16
    typedef logic [SEQ_WIDTH-1:0] seq_t;

    ////////////////////
    // Drop statistics

    localparam int DROP_WIDTH = 8;

    // Saturates at all ones
    typedef logic [DROP_WIDTH-1:0] drop_count_t;

    ////////////////////
    // Consumer FSM

    typedef enum logic {
        EGRESS_EMPTY,
        EGRESS_FULL
    } egress_state_e;

endpackage : stream_pkg

`default_nettype wire

// ==== logic/counter_bin.sv ====
`default_nettype none

module counter_bin #(
    parameter int WIDTH = 3,
    parameter int MAX   = 4
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_enable,
    output logic [WIDTH-1:0] o_counter_bin,
    output logic [WIDTH-1:0] ow_counter_bin_next
);

    // Last value of the low bits before the wrap
    localparam logic [WIDTH-2:0] LAST = (WIDTH-1)'(MAX - 1);

    // Look-ahead value, top bit flips on every wrap
    always_comb begin
        ow_counter_bin_next = o_counter_bin;
        if (i_enable) begin
            if (o_counter_bin[WIDTH-2:0] == LAST) begin
                ow_counter_bin_next = {~o_counter_bin[WIDTH-1], {(WIDTH-1){1'b0}}};
            end else begin
                ow_counter_bin_next = o_counter_bin + WIDTH'(1);
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_counter_bin <= '0;
        end else begin
            o_counter_bin <= ow_counter_bin_next;
        end
    end

endmodule : counter_bin

`default_nettype wire

// ==== logic/fifo_control.sv ====
`default_nettype none

module fifo_control #(
    parameter int DEPTH            = 4,
    parameter int ADDR_WIDTH       = 2,
    parameter int ALMOST_WR_MARGIN = 1
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic [ADDR_WIDTH:0] i_wr_ptr_next,
    input  logic [ADDR_WIDTH:0] i_rd_ptr_next,
    output logic                o_full,
    output logic                o_empty,
    output logic                o_almost_full
);

    localparam int PW = ADDR_WIDTH + 1;

    // Occupancy thresholds in pointer width
    localparam logic [ADDR_WIDTH:0] DEPTH_V      = PW'(DEPTH);
    localparam logic [ADDR_WIDTH:0] ALMOST_LEVEL = PW'(DEPTH - ALMOST_WR_MARGIN);

    logic [ADDR_WIDTH-1:0] w_wr_addr;
    logic [ADDR_WIDTH-1:0] w_rd_addr;
    logic                  w_same_lap;
    logic [ADDR_WIDTH:0]   w_count;

    ////////////////////
    // Occupancy

    assign w_wr_addr  = i_wr_ptr_next[ADDR_WIDTH-1:0];
    assign w_rd_addr  = i_rd_ptr_next[ADDR_WIDTH-1:0];
    assign w_same_lap = (i_wr_ptr_next[ADDR_WIDTH] == i_rd_ptr_next[ADDR_WIDTH]);

    // Low bits wrap at DEPTH, so a different lap adds DEPTH back
    always_comb begin
        if (w_same_lap) begin
            w_count = {1'b0, w_wr_addr} - {1'b0, w_rd_addr};
        end else begin
            w_count = DEPTH_V - {1'b0, w_rd_addr} + {1'b0, w_wr_addr};
        end
    end

    ////////////////////
    // Registered flags

    // Next pointers in, so flags change on the same edge as the access
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_empty       <= 1'b1;
            o_full        <= 1'b0;
            o_almost_full <= 1'b0;
        end else begin
            o_empty       <= (w_count == '0);
            o_full        <= (w_count == DEPTH_V);
            o_almost_full <= (w_count >= ALMOST_LEVEL);
        end
    end

endmodule : fifo_control

`default_nettype wire

// ==== logic/fifo_axi_sync.sv ====
`default_nettype none

module fifo_axi_sync #(
    parameter int DATA_WIDTH       = 8,
    parameter int DEPTH            = 4,
    parameter int ALMOST_WR_MARGIN = 1
) (
    input  logic                                          i_clk,
    input  logic                                          i_rst_n,
    input  logic                                          i_wr_valid,
    output logic                                          o_wr_ready,
    input  logic [DATA_WIDTH+stream_pkg::SEQ_WIDTH-1:0] i_wr_data,
    input  logic                                          i_rd_ready,
    output logic                                          o_rd_valid,
    output logic                                          o_almost_full,
    output logic [DATA_WIDTH+stream_pkg::SEQ_WIDTH-1:0] ow_rd_data
);

    // Stored word is tag plus sample
    localparam int WW = DATA_WIDTH + stream_pkg::SEQ_WIDTH;
    localparam int AW = $clog2(DEPTH);

    logic [AW:0]   r_wr_ptr;
    logic [AW:0]   r_rd_ptr;
    logic [AW:0]   w_wr_ptr_next;
    logic [AW:0]   w_rd_ptr_next;
    logic          r_full;
    logic          r_empty;
    logic          w_write;
    logic          w_read;

    logic [WW-1:0] r_mem [DEPTH];

    // Misuse is blocked here, the flags gate both sides
    assign w_write = i_wr_valid && !r_full;
    assign w_read  = i_rd_ready && !r_empty;

    ////////////////////
    // Pointers

    counter_bin #(
        .WIDTH (AW + 1),
        .MAX   (DEPTH)
    ) wr_ptr0 (
        .i_clk               (i_clk),
        .i_rst_n             (i_rst_n),
        .i_enable            (w_write),
        .o_counter_bin       (r_wr_ptr),
        .ow_counter_bin_next (w_wr_ptr_next)
    );

    counter_bin #(
        .WIDTH (AW + 1),
        .MAX   (DEPTH)
    ) rd_ptr0 (
        .i_clk               (i_clk),
        .i_rst_n             (i_rst_n),
        .i_enable            (w_read),
        .o_counter_bin       (r_rd_ptr),
        .ow_counter_bin_next (w_rd_ptr_next)
    );

    ////////////////////
    // Flags

    fifo_control #(
        .DEPTH            (DEPTH),
        .ADDR_WIDTH       (AW),
        .ALMOST_WR_MARGIN (ALMOST_WR_MARGIN)
    ) ctrl0 (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_wr_ptr_next (w_wr_ptr_next),
        .i_rd_ptr_next (w_rd_ptr_next),
        .o_full        (r_full),
        .o_empty       (r_empty),
        .o_almost_full (o_almost_full)
    );

    assign o_wr_ready = !r_full;
    assign o_rd_valid = !r_empty;

    ////////////////////
    // Storage

    always_ff @(posedge i_clk) begin
        if (w_write) begin
            r_mem[r_wr_ptr[AW-1:0]] <= i_wr_data;
        end
    end

    // Head word, combinational
    assign ow_rd_data = r_mem[r_rd_ptr[AW-1:0]];

endmodule : fifo_axi_sync

`default_nettype wire

// ==== logic/stream_ingress.sv ====
`default_nettype none

module stream_ingress #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                                          i_clk,
    input  logic                                          i_rst_n,
    input  logic                                          i_in_valid,
    input  logic [DATA_WIDTH-1:0]                         i_in_data,
    input  logic                                          i_wr_ready,
    output logic                                          o_wr_valid,
    output logic [DATA_WIDTH+stream_pkg::SEQ_WIDTH-1:0] o_wr_data,
    output stream_pkg::drop_count_t                       o_drop_count
);

    stream_pkg::seq_t r_seq;
    logic             w_accept;
    logic             w_drop;

    ////////////////////
    // Write side

    // Strobe goes straight through, no holding register
    assign o_wr_valid = i_in_valid;
    assign o_wr_data  = {r_seq, i_in_data};

    assign w_accept = i_in_valid && i_wr_ready;
    assign w_drop   = i_in_valid && !i_wr_ready;

    // Tag only moves on an accepted write
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_seq <= '0;
        end else if (w_accept) begin
            r_seq <= r_seq + stream_pkg::seq_t'(1);
        end
    end

    ////////////////////
    // Drop counter

    // Sticks at all ones
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_drop_count <= '0;
        end else if (w_drop && (o_drop_count != '1)) begin
            o_drop_count <= o_drop_count + stream_pkg::drop_count_t'(1);
        end
    end

endmodule : stream_ingress

`default_nettype wire

// ==== logic/stream_egress.sv ====
`default_nettype none

module stream_egress #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                                          i_clk,
    input  logic                                          i_rst_n,
    input  logic                                          i_rd_valid,
    input  logic [DATA_WIDTH+stream_pkg::SEQ_WIDTH-1:0] i_rd_data,
    output logic                                          o_rd_ready,
    input  logic                                          i_out_ready,
    output logic                                          o_out_valid,
    output logic [DATA_WIDTH-1:0]                         o_out_data,
    output stream_pkg::seq_t                              o_out_seq
);

    localparam int WW = DATA_WIDTH + stream_pkg::SEQ_WIDTH;

    stream_pkg::egress_state_e r_state;
    stream_pkg::egress_state_e w_state_next;
    logic [WW-1:0]             r_word;
    logic                      w_pop;

    ////////////////////
    // Pop control

    // Room when empty, or when the held word leaves this edge
    assign o_rd_ready = (r_state == stream_pkg::EGRESS_EMPTY) || i_out_ready;
    assign w_pop      = i_rd_valid && o_rd_ready;

    always_comb begin
        w_state_next = r_state;
        case (r_state)
            stream_pkg::EGRESS_EMPTY: begin
                if (w_pop) begin
                    w_state_next = stream_pkg::EGRESS_FULL;
                end
            end
            stream_pkg::EGRESS_FULL: begin
                // Sink took the word, refill or go idle
                if (i_out_ready && !w_pop) begin
                    w_state_next = stream_pkg::EGRESS_EMPTY;
                end
            end
            default: w_state_next = stream_pkg::EGRESS_EMPTY;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_state <= stream_pkg::EGRESS_EMPTY;
        end else begin
            r_state <= w_state_next;
        end
    end

    ////////////////////
    // Output register

    always_ff @(posedge i_clk) begin
        if (w_pop) begin
            r_word <= i_rd_data;
        end
    end

    assign o_out_valid = (r_state == stream_pkg::EGRESS_FULL);
    assign o_out_data  = r_word[DATA_WIDTH-1:0];
    assign o_out_seq   = r_word[WW-1:DATA_WIDTH];

endmodule : stream_egress

`default_nettype wire

// ==== logic/stream_buffer_top.sv ====
`default_nettype none

module stream_buffer_top #(
    parameter int DATA_WIDTH       = 8,
    parameter int DEPTH            = 4,
    parameter int ALMOST_WR_MARGIN = 1
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_in_valid,
    input  logic [DATA_WIDTH-1:0]   i_in_data,
    input  logic                    i_out_ready,
    output logic                    o_out_valid,
    output logic [DATA_WIDTH-1:0]   o_out_data,
    output stream_pkg::seq_t        o_out_seq,
    output stream_pkg::drop_count_t o_drop_count,
    output logic                    o_almost_full
);

    localparam int WW = DATA_WIDTH + stream_pkg::SEQ_WIDTH;

    // Producer to FIFO
    logic          w_wr_valid;
    logic          w_wr_ready;
    logic [WW-1:0] w_wr_data;

    // FIFO to consumer
    logic          w_rd_valid;
    logic          w_rd_ready;
    logic [WW-1:0] w_rd_data;

    stream_ingress #(
        .DATA_WIDTH (DATA_WIDTH)
    ) ingress0 (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_in_valid   (i_in_valid),
        .i_in_data    (i_in_data),
        .i_wr_ready   (w_wr_ready),
        .o_wr_valid   (w_wr_valid),
        .o_wr_data    (w_wr_data),
        .o_drop_count (o_drop_count)
    );

    fifo_axi_sync #(
        .DATA_WIDTH       (DATA_WIDTH),
        .DEPTH            (DEPTH),
        .ALMOST_WR_MARGIN (ALMOST_WR_MARGIN)
    ) fifo0 (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_wr_valid    (w_wr_valid),
        .o_wr_ready    (w_wr_ready),
        .i_wr_data     (w_wr_data),
        .i_rd_ready    (w_rd_ready),
        .o_rd_valid    (w_rd_valid),
        .o_almost_full (o_almost_full),
        .ow_rd_data    (w_rd_data)
    );

    stream_egress #(
        .DATA_WIDTH (DATA_WIDTH)
    ) egress0 (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_rd_valid  (w_rd_valid),
        .i_rd_data   (w_rd_data),
        .o_rd_ready  (w_rd_ready),
        .i_out_ready (i_out_ready),
        .o_out_valid (o_out_valid),
        .o_out_data  (o_out_data),
        .o_out_seq   (o_out_seq)
    );

endmodule : stream_buffer_top

`default_nettype wire

// ==== tests/stream_buffer_props.sv ====
`default_nettype none

module stream_buffer_props #(
    parameter int WORD_WIDTH = 12
) (
    input logic                  i_clk,
    input logic                  i_rst_n,
    input logic                  i_write,
    input logic                  i_read,
    input logic                  i_full,
    input logic                  i_empty,
    input logic                  i_out_valid,
    input logic                  i_out_ready,
    input logic [WORD_WIDTH-1:0] i_out_word
);

    ////////////////////
    // FIFO misuse

    write_while_full: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) !(i_write && i_full)
    ) else $error("Write accepted while the FIFO is full");

    pop_while_empty: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) !(i_read && i_empty)
    ) else $error("Pop taken while the FIFO is empty");

    ////////////////////
    // Output stage

    // Held word must not move until the sink takes it
    hold_under_stall: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_out_valid && !i_out_ready) |=> (i_out_valid && $stable(i_out_word))
    ) else $error("Output changed while stalled");

    idle_after_reset: assert property (
        @(posedge i_clk) $rose(i_rst_n) |-> !i_out_valid
    ) else $error("Output valid right after reset");

endmodule : stream_buffer_props

// FIFO side with the output ports tied idle
// Full and empty decoded from the registered pointers
bind fifo_axi_sync stream_buffer_props #(.WORD_WIDTH (WW)) fifo_props0 (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    // A write or pop is a pointer that moves on this edge
    .i_write     (w_wr_ptr_next != r_wr_ptr),
    .i_read      (w_rd_ptr_next != r_rd_ptr),
    .i_full      ((r_wr_ptr[AW] != r_rd_ptr[AW]) && (r_wr_ptr[AW-1:0] == r_rd_ptr[AW-1:0])),
    .i_empty     (r_wr_ptr == r_rd_ptr),
    .i_out_valid (1'b0), .i_out_ready (1'b1), .i_out_word ('0)
);

// Output side with the FIFO ports tied idle
bind stream_egress stream_buffer_props #(.WORD_WIDTH (WW)) egress_props0 (
    .i_clk (i_clk), .i_rst_n (i_rst_n),
    .i_write (1'b0), .i_read (1'b0), .i_full (1'b0), .i_empty (1'b1),
    .i_out_valid (o_out_valid), .i_out_ready (i_out_ready),
    .i_out_word ({o_out_seq, o_out_data})
);

`default_nettype wire

// ==== tests/tb_stream_buffer.sv ====
`default_nettype none

module tb_stream_buffer;

    localparam int DATA_WIDTH  = 8;
    localparam int DEPTH       = 4;
    localparam int WW          = DATA_WIDTH + stream_pkg::SEQ_WIDTH;
    localparam int CAPACITY    = DEPTH + 1;
    localparam int NUM_ROWS    = 4;
    localparam int DRIVE_DELAY = 2;
    localparam int SINK_ALWAYS = 0;
    localparam int SINK_STALL  = 1;
    localparam int SINK_ALT    = 2;

    logic                    i_clk;
    logic                    i_rst_n;
    logic                    i_in_valid;
    logic [DATA_WIDTH-1:0]   i_in_data;
    logic                    i_out_ready;
    logic                    o_out_valid;
    logic [DATA_WIDTH-1:0]   o_out_data;
    stream_pkg::seq_t        o_out_seq;
    stream_pkg::drop_count_t o_drop_count;
    logic                    o_almost_full;

    // Stimulus table, one entry per row
    string row_name    [NUM_ROWS];
    int    row_strobes [NUM_ROWS];
    int    row_gap     [NUM_ROWS];
    int    row_sink    [NUM_ROWS];
    int    row_drops   [NUM_ROWS];
    int    row_latency [NUM_ROWS];

    // Reference queue of {tag, data}
    logic [WW-1:0]    exp_q [$];
    logic [WW-1:0]    exp_word;
    stream_pkg::seq_t exp_seq;
    logic             accept;
    logic             monitor_on;
    logic             alt_phase;
    int               beat_count;
    int               err_count;
    int               rows_passed;
    int               cycle_count;
    int               timeout_cycles;
    int               r;

    stream_buffer_top #(
        .DATA_WIDTH       (DATA_WIDTH),
        .DEPTH            (DEPTH),
        .ALMOST_WR_MARGIN (1)
    ) dut0 (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_in_valid    (i_in_valid),
        .i_in_data     (i_in_data),
        .i_out_ready   (i_out_ready),
        .o_out_valid   (o_out_valid),
        .o_out_data    (o_out_data),
        .o_out_seq     (o_out_seq),
        .o_drop_count  (o_drop_count),
        .o_almost_full (o_almost_full)
    );

    always #20 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout after %0d cycles, the stream stopped making progress", cycle_count);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic log_error(input string msg);
        err_count++;
        $display("%s", msg);
    endtask

    ////////////////////
    // Reference model

    // Inputs are stable here, so this looks ahead at the coming edge
    always @(negedge i_clk) begin
        if (monitor_on) begin
            // Capacity is judged before this edge's beat leaves the path
            accept = i_in_valid && (exp_q.size() < CAPACITY);
            if (o_out_valid && i_out_ready) begin
                beat_count++;
                assert (exp_q.size() != 0) else log_error("Output beat while no sample was expected");
                exp_word = exp_q.pop_front();
                assert (o_out_data == exp_word[DATA_WIDTH-1:0]) else log_error($sformatf(
                    "Mismatch o_out_data: got 0x%h, expected 0x%h",
                    o_out_data, exp_word[DATA_WIDTH-1:0]));
                assert (o_out_seq == exp_word[WW-1:DATA_WIDTH]) else log_error($sformatf(
                    "Mismatch o_out_seq: got 0x%h, expected 0x%h",
                    o_out_seq, exp_word[WW-1:DATA_WIDTH]));
            end
            if (accept) begin
                exp_q.push_back({exp_seq, i_in_data});
                exp_seq = exp_seq + stream_pkg::seq_t'(1);
            end
        end
    end

    ////////////////////
    // Stimulus

    task automatic set_row(input int idx, input string name, input int strobes,
                           input int gap, input int sink, input int latency);
        row_name[idx]    = name;
        row_strobes[idx] = strobes;
        row_gap[idx]     = gap;
        row_sink[idx]    = sink;
        row_latency[idx] = latency;
        // Only a stalled sink overflows, once DEPTH + 1 samples are held
        row_drops[idx] = (sink == SINK_STALL && strobes > CAPACITY) ? strobes - CAPACITY : 0;
        timeout_cycles += strobes * (gap + 2);
    endtask

    function automatic logic sink_ready(input int pattern, input logic phase,
                                        input logic strobing);
        case (pattern)
            SINK_ALWAYS: return 1'b1;
            SINK_STALL:  return !strobing;
            default:     return phase;
        endcase
    endfunction

    task automatic drive_cycle(input logic valid, input logic [DATA_WIDTH-1:0] data,
                               input int pattern, input logic strobing);
        @(posedge i_clk);
        #DRIVE_DELAY;
        alt_phase   = ~alt_phase;
        i_in_valid  = valid;
        i_in_data   = data;
        i_out_ready = sink_ready(pattern, alt_phase, strobing);
    endtask

    task automatic sample_point;
        @(negedge i_clk);
        #1;
    endtask

    task automatic check_held_output;
        assert (o_almost_full) else log_error("o_almost_full is low while the sink is stalled");
        assert (o_out_valid) else log_error("o_out_valid is low while samples are held");
        assert (o_out_data == exp_q[0][DATA_WIDTH-1:0]) else log_error($sformatf(
            "Mismatch o_out_data: got 0x%h, expected 0x%h", o_out_data, exp_q[0][DATA_WIDTH-1:0]));
        assert (o_out_seq == exp_q[0][WW-1:DATA_WIDTH]) else log_error($sformatf(
            "Mismatch o_out_seq: got 0x%h, expected 0x%h", o_out_seq, exp_q[0][WW-1:DATA_WIDTH]));
    endtask

    task automatic drain(input int pattern);
        while (exp_q.size() != 0 || o_out_valid) begin
            drive_cycle(1'b0, '0, pattern, 1'b0);
            sample_point();
        end
    endtask

    task automatic run_row(input int idx);
        int drops_before;
        int beats_before;
        int errs_before;
        int s;
        int g;
        int lat;
        drops_before = o_drop_count;
        beats_before = beat_count;
        errs_before  = err_count;
        for (s = 0; s < row_strobes[idx]; s++) begin
            drive_cycle(1'b1, DATA_WIDTH'($urandom), row_sink[idx], 1'b1);
            for (g = 0; g < row_gap[idx]; g++) begin
                drive_cycle(1'b0, '0, row_sink[idx], 1'b1);
            end
        end
        if (row_latency[idx] != 0) begin
            lat = 0;
            do begin
                drive_cycle(1'b0, '0, row_sink[idx], 1'b1);
                lat++;
                sample_point();
            end while (!o_out_valid && lat < 8);
            assert (lat == row_latency[idx]) else log_error($sformatf(
                "Sample reached the output after %0d cycles instead of %0d",
                lat, row_latency[idx]));
        end
        // Sink keeps its strobing behavior a little longer
        repeat (2) begin
            drive_cycle(1'b0, '0, row_sink[idx], 1'b1);
            sample_point();
            if (row_sink[idx] == SINK_STALL) begin
                check_held_output();
            end
        end
        drain(row_sink[idx]);
        assert (int'(o_drop_count) == drops_before + row_drops[idx]) else log_error($sformatf(
            "Mismatch o_drop_count: got 0x%h, expected 0x%h",
            o_drop_count, drops_before + row_drops[idx]));
        assert (beat_count - beats_before == row_strobes[idx] - row_drops[idx])
            else log_error($sformatf("Delivered %0d samples, expected %0d",
                beat_count - beats_before, row_strobes[idx] - row_drops[idx]));
        assert (!o_almost_full) else log_error("Mismatch o_almost_full: got 0x1, expected 0x0");
        if (err_count == errs_before) begin
            rows_passed++;
            $display("Test %-12s passed", row_name[idx]);
        end else begin
            $display("Test %-12s failed with %0d errors", row_name[idx], err_count - errs_before);
        end
    endtask

    initial begin
        void'($urandom(14550));
        i_clk          = 1'b0;
        i_rst_n        = 1'b0;
        i_in_valid     = 1'b0;
        i_in_data      = '0;
        i_out_ready    = 1'b0;
        monitor_on     = 1'b0;
        alt_phase      = 1'b0;
        exp_seq        = '0;
        beat_count     = 0;
        err_count      = 0;
        rows_passed    = 0;
        cycle_count    = 0;
        timeout_cycles = 50;
        set_row(0, "single", 1, 0, SINK_ALWAYS, 2);
        set_row(1, "burst", 20, 0, SINK_ALWAYS, 0);
        set_row(2, "stall", DEPTH + 3, 0, SINK_STALL, 0);
        set_row(3, "alternate", 12, 2, SINK_ALT, 0);

        repeat (8) @(posedge i_clk);
        #DRIVE_DELAY;
        i_rst_n    = 1'b1;
        monitor_on = 1'b1;
        sample_point();
        assert (!o_out_valid) else log_error("Mismatch o_out_valid: got 0x1, expected 0x0");
        assert (!o_almost_full) else log_error("Mismatch o_almost_full: got 0x1, expected 0x0");
        assert (o_drop_count == '0) else log_error($sformatf(
            "Mismatch o_drop_count: got 0x%h, expected 0x00", o_drop_count));
        if (err_count == 0) begin
            rows_passed++;
            $display("Test %-12s passed", "reset_state");
        end else begin
            $display("Test %-12s failed with %0d errors", "reset_state", err_count);
        end

        for (r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        $display("Tests run %0d, passed %0d, errors %0d", NUM_ROWS + 1, rows_passed, err_count);
        if (err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_stream_buffer

`default_nettype wire

// ==== files.f ====
logic/stream_pkg.sv
logic/counter_bin.sv
logic/fifo_control.sv
logic/fifo_axi_sync.sv
logic/stream_ingress.sv
logic/stream_egress.sv
logic/stream_buffer_top.sv
tests/stream_buffer_props.sv
tests/tb_stream_buffer.sv

// ==== Bender.yml ====
package:
  name: stream_buffer

sources:
  - files:
      - logic/stream_pkg.sv
      - logic/counter_bin.sv
      - logic/fifo_control.sv
      - logic/fifo_axi_sync.sv
      - logic/stream_ingress.sv
      - logic/stream_egress.sv
      - logic/stream_buffer_top.sv
  - target: test
    files:
      - tests/stream_buffer_props.sv
      - tests/tb_stream_buffer.sv
